/* logic/ca_code_gen.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module ca_code_gen
   import gps_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  logic        sample_valid_i,
   input  prn_t        prn_i,
   input  logic        seek_en_i,
   input  chip_shift_t seek_target_i,
   output logic        chip_valid_o,
   output logic        chip_o,
   output chip_shift_t code_shift_o,
   output logic        seeking_o
);

   logic [10:1] g1;
   logic [10:1] g2;
   logic [3:0]  tap_a;
   logic [3:0]  tap_b;
   logic        code_chip;
   code_phase_t code_phase;
   code_phase_t phase_next;
   logic        phase_carry;
   logic        chip_step;
   logic        code_wrap;
   logic        seek_done;
   chip_shift_t seek_target_q;
   prn_t        prn_q;
   seek_state_t state;

   // G2 phase selects per satellite.
   always_comb begin
      case (prn_i)
         5'd1:    {tap_a, tap_b} = {4'd2, 4'd6};
         5'd2:    {tap_a, tap_b} = {4'd3, 4'd7};
         5'd3:    {tap_a, tap_b} = {4'd4, 4'd8};
         5'd4:    {tap_a, tap_b} = {4'd5, 4'd9};
         5'd5:    {tap_a, tap_b} = {4'd1, 4'd9};
         5'd6:    {tap_a, tap_b} = {4'd2, 4'd10};
         5'd7:    {tap_a, tap_b} = {4'd1, 4'd8};
         5'd8:    {tap_a, tap_b} = {4'd2, 4'd9};
         5'd9:    {tap_a, tap_b} = {4'd3, 4'd10};
         5'd10:   {tap_a, tap_b} = {4'd2, 4'd3};
         5'd11:   {tap_a, tap_b} = {4'd3, 4'd4};
         5'd12:   {tap_a, tap_b} = {4'd5, 4'd6};
         5'd13:   {tap_a, tap_b} = {4'd6, 4'd7};
         5'd14:   {tap_a, tap_b} = {4'd7, 4'd8};
         5'd15:   {tap_a, tap_b} = {4'd8, 4'd9};
         5'd16:   {tap_a, tap_b} = {4'd9, 4'd10};
         5'd17:   {tap_a, tap_b} = {4'd1, 4'd4};
         5'd18:   {tap_a, tap_b} = {4'd2, 4'd5};
         5'd19:   {tap_a, tap_b} = {4'd3, 4'd6};
         5'd20:   {tap_a, tap_b} = {4'd4, 4'd7};
         5'd21:   {tap_a, tap_b} = {4'd5, 4'd8};
         5'd22:   {tap_a, tap_b} = {4'd6, 4'd9};
         5'd23:   {tap_a, tap_b} = {4'd1, 4'd3};
         5'd24:   {tap_a, tap_b} = {4'd4, 4'd6};
         5'd25:   {tap_a, tap_b} = {4'd5, 4'd7};
         5'd26:   {tap_a, tap_b} = {4'd6, 4'd8};
         5'd27:   {tap_a, tap_b} = {4'd7, 4'd9};
         5'd28:   {tap_a, tap_b} = {4'd8, 4'd10};
         5'd29:   {tap_a, tap_b} = {4'd1, 4'd6};
         5'd30:   {tap_a, tap_b} = {4'd2, 4'd7};
         5'd31:   {tap_a, tap_b} = {4'd3, 4'd8};
         default: {tap_a, tap_b} = {4'd4, 4'd9};
      endcase
   end

   assign code_chip = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Carry out of the code oscillator marks the end of a chip.
   assign {phase_carry, phase_next} = {1'b0, code_phase} + {1'b0, `CODE_INC};

   // Seek steps only on cycles free of a strobe.
   assign chip_step = (sample_valid_i && phase_carry) ||
                      (state == SEEK && !sample_valid_i && code_shift_o != seek_target_q);
   assign code_wrap = code_shift_o == chip_shift_t'(`CODE_LENGTH - 1);
   assign seek_done = state == SEEK && code_shift_o == seek_target_q && !chip_step;
   assign seeking_o = state == SEEK;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         g1           <= '1;
         g2           <= '1;
         code_shift_o <= '0;
         code_phase   <= '0;
         prn_q        <= prn_i;
      end else if (prn_i != prn_q) begin
         // New satellite restarts the code at chip 0.
         g1           <= '1;
         g2           <= '1;
         code_shift_o <= '0;
         code_phase   <= '0;
         prn_q        <= prn_i;
      end else begin
         if (sample_valid_i) begin
            code_phase <= phase_next;
         end
         if (chip_step && code_wrap) begin
            g1           <= '1;
            g2           <= '1;
            code_shift_o <= '0;
         end else if (chip_step) begin
            g1           <= {g1[9:1], g1[3] ^ g1[10]};
            g2           <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
            code_shift_o <= code_shift_o + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state        <= IDLE;
         chip_valid_o <= 1'b0;
      end else begin
         chip_valid_o <= sample_valid_i;
         if (seek_en_i) begin
            state <= SEEK;
         end else if (seek_done) begin
            state <= IDLE;
         end
      end
   end

   // Chip for the current sample, taken before the code advances.
   always_ff @(posedge clk) begin
      if (sample_valid_i) begin
         chip_o <= code_chip;
      end
      if (seek_en_i) begin
         seek_target_q <= seek_target_i;
      end
   end

endmodule

/* logic/carrier_mixer.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module carrier_mixer
   import gps_pkg::*;
(
   input  logic     clk,
   input  logic     rst_i,
   input  logic     valid_i,
   input  sample_t  sample_i,
   input  logic     chip_i,
   input  doppler_t doppler_i,
   output logic     valid_o,
   output logic     chip_o,
   output product_t prod_i_o,
   output product_t prod_q_o
);

   localparam int DOPPLER_PAD = `CARRIER_ACC_WIDTH - `DOPPLER_WIDTH;

   carrier_phase_t phase;
   carrier_phase_t phase_inc;
   lut_index_t     lut_index;
   lut_value_t     cos_value;
   lut_value_t     sin_value;

   // IF plus the signed Doppler offset.
   assign phase_inc = `F_IF_INC + {{DOPPLER_PAD{doppler_i[`DOPPLER_WIDTH-1]}}, doppler_i};
   assign lut_index = phase[`CARRIER_ACC_WIDTH-1 -: `LUT_INDEX_WIDTH];

   // Eight-step cosine and sine.
   always_comb begin
      case (lut_index)
         3'd0:    {cos_value, sin_value} = {lut_value_t'(2), lut_value_t'(0)};
         3'd1:    {cos_value, sin_value} = {lut_value_t'(1), lut_value_t'(1)};
         3'd2:    {cos_value, sin_value} = {lut_value_t'(0), lut_value_t'(2)};
         3'd3:    {cos_value, sin_value} = {lut_value_t'(-1), lut_value_t'(1)};
         3'd4:    {cos_value, sin_value} = {lut_value_t'(-2), lut_value_t'(0)};
         3'd5:    {cos_value, sin_value} = {lut_value_t'(-1), lut_value_t'(-1)};
         3'd6:    {cos_value, sin_value} = {lut_value_t'(0), lut_value_t'(-2)};
         default: {cos_value, sin_value} = {lut_value_t'(1), lut_value_t'(-1)};
      endcase
   end

   // The table reads the phase from before this sample's update.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         phase   <= '0;
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
         if (valid_i) begin
            phase <= phase + phase_inc;
         end
      end
   end

   // Wiped products travel with their chip.
   always_ff @(posedge clk) begin
      if (valid_i) begin
         prod_i_o <= product_t'(sample_i) * product_t'(cos_value);
         prod_q_o <= product_t'(sample_i) * product_t'(sin_value);
         chip_o   <= chip_i;
      end
   end

endmodule

/* logic/code_accumulator.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module code_accumulator
   import gps_pkg::*;
(
   input  logic     clk,
   input  logic     rst_i,
   input  logic     valid_i,
   input  logic     chip_i,
   input  product_t prod_i_i,
   input  product_t prod_q_i,
   input  logic     clear_i,
   output logic     update_o,
   output accum_t   acc_i_o,
   output accum_t   acc_q_o
);

   accum_t term_i;
   accum_t term_q;

   // Chip 1 flips the sign, chip 0 passes.
   function automatic accum_t code_wipe(input logic chip, input product_t prod);
      accum_t ext;
      ext = accum_t'(prod);
      return chip ? -ext : ext;
   endfunction

   assign term_i = code_wipe(chip_i, prod_i_i);
   assign term_q = code_wipe(chip_i, prod_q_i);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         acc_i_o  <= '0;
         acc_q_o  <= '0;
         update_o <= 1'b0;
      end else begin
         update_o <= valid_i;
         if (clear_i) begin
            // A product in the clear cycle starts the new sum.
            acc_i_o <= valid_i ? term_i : '0;
            acc_q_o <= valid_i ? term_q : '0;
         end else if (valid_i) begin
            acc_i_o <= acc_i_o + term_i;
            acc_q_o <= acc_q_o + term_q;
         end
      end
   end

endmodule

/* logic/gps_defs.svh */
`ifndef GPS_DEFS_SVH
`define GPS_DEFS_SVH

// Front-end sample and Doppler word widths.
`define SAMPLE_WIDTH       4
`define DOPPLER_WIDTH      16

// Carrier oscillator and its cosine/sine table.
`define CARRIER_ACC_WIDTH  24
`define LUT_INDEX_WIDTH    3
`define LUT_WIDTH          3
`define F_IF_INC           24'h2AAAAB

// Carrier-wiped product and correlation sum widths.
`define PRODUCT_WIDTH      7
`define ACC_WIDTH          20

// Code oscillator; 16'h4000 gives exactly four samples per chip.
`define CODE_ACC_WIDTH     16
`define CODE_INC           16'h4000
`define CODE_LENGTH        1023
`define CHIP_SHIFT_WIDTH   10
`define PRN_WIDTH          5

// Cycles a sample waits for its chip.
`define ALIGN_DELAY        1

`endif

/* logic/gps_pkg.sv */
`include "gps_defs.svh"

package gps_pkg;

   // Front-end data and carrier control.
   typedef logic signed [`SAMPLE_WIDTH-1:0]  sample_t;
   typedef logic signed [`DOPPLER_WIDTH-1:0] doppler_t;

   // Oscillator phases.
   typedef logic [`CARRIER_ACC_WIDTH-1:0] carrier_phase_t;
   typedef logic [`CODE_ACC_WIDTH-1:0]    code_phase_t;

   // Carrier table.
   typedef logic [`LUT_INDEX_WIDTH-1:0]  lut_index_t;
   typedef logic signed [`LUT_WIDTH-1:0] lut_value_t;

   // Mixer and accumulator data.
   typedef logic signed [`PRODUCT_WIDTH-1:0] product_t;
   typedef logic signed [`ACC_WIDTH-1:0]     accum_t;

   // Code position and satellite select; PRN 32 is encoded as 0.
   typedef logic [`CHIP_SHIFT_WIDTH-1:0] chip_shift_t;
   typedef logic [`PRN_WIDTH-1:0]        prn_t;

   typedef enum logic {
      IDLE,
      SEEK
   } seek_state_t;

endpackage

/* logic/sample_align.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module sample_align
   import gps_pkg::*;
(
   input  logic    clk,
   input  logic    rst_i,
   input  logic    sample_valid_i,
   input  sample_t sample_i,
   output logic    valid_o,
   output sample_t sample_o
);

   logic [`ALIGN_DELAY-1:0] valid_pipe;
   sample_t                 sample_pipe [`ALIGN_DELAY];

   // Strobe stages.
   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe[0] <= sample_valid_i;
         for (int i = 1; i < `ALIGN_DELAY; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   // Sample stages.
   always_ff @(posedge clk) begin
      sample_pipe[0] <= sample_i;
      for (int i = 1; i < `ALIGN_DELAY; i++) begin
         sample_pipe[i] <= sample_pipe[i-1];
      end
   end

   assign valid_o  = valid_pipe[`ALIGN_DELAY-1];
   assign sample_o = sample_pipe[`ALIGN_DELAY-1];

endmodule

/* logic/subchannel.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module subchannel
   import gps_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  logic        sample_valid_i,
   input  sample_t     sample_i,
   input  doppler_t    doppler_i,
   input  prn_t        prn_i,
   input  logic        seek_en_i,
   input  chip_shift_t seek_target_i,
   input  logic        acc_clear_i,
   output chip_shift_t code_shift_o,
   output logic        seeking_o,
   output logic        acc_update_o,
   output accum_t      acc_i_o,
   output accum_t      acc_q_o,
   output logic        chip_o
);

   logic     chip_valid;
   logic     aligned_valid;
   sample_t  aligned_sample;
   logic     mix_valid;
   logic     mix_chip;
   product_t prod_i;
   product_t prod_q;

   // Code generator.
   ca_code_gen u_ca_code_gen (
      .clk            (clk),
      .rst_i          (rst_i),
      .sample_valid_i (sample_valid_i),
      .prn_i          (prn_i),
      .seek_en_i      (seek_en_i),
      .seek_target_i  (seek_target_i),
      .chip_valid_o   (chip_valid),
      .chip_o         (chip_o),
      .code_shift_o   (code_shift_o),
      .seeking_o      (seeking_o)
   );

   // Sample waits one cycle for its chip.
   sample_align u_sample_align (
      .clk            (clk),
      .rst_i          (rst_i),
      .sample_valid_i (sample_valid_i),
      .sample_i       (sample_i),
      .valid_o        (aligned_valid),
      .sample_o       (aligned_sample)
   );

   carrier_mixer u_carrier_mixer (
      .clk       (clk),
      .rst_i     (rst_i),
      .valid_i   (aligned_valid & chip_valid),
      .sample_i  (aligned_sample),
      .chip_i    (chip_o),
      .doppler_i (doppler_i),
      .valid_o   (mix_valid),
      .chip_o    (mix_chip),
      .prod_i_o  (prod_i),
      .prod_q_o  (prod_q)
   );

   code_accumulator u_code_accumulator (
      .clk      (clk),
      .rst_i    (rst_i),
      .valid_i  (mix_valid),
      .chip_i   (mix_chip),
      .prod_i_i (prod_i),
      .prod_q_i (prod_q),
      .clear_i  (acc_clear_i),
      .update_o (acc_update_o),
      .acc_i_o  (acc_i_o),
      .acc_q_o  (acc_q_o)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the subchannel testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f subchannel.f \
   --top-module subchannel_tb -o subchannel_sim
./obj_dir/subchannel_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failures"

/* subchannel.f */
+incdir+logic
logic/gps_pkg.sv
logic/ca_code_gen.sv
logic/sample_align.sv
logic/carrier_mixer.sv
logic/code_accumulator.sv
logic/subchannel.sv
testbench/subchannel_tb.sv

/* testbench/subchannel_tb.sv */
`timescale 1ns/1ps
`include "gps_defs.svh"

module subchannel_tb
   import gps_pkg::*;
();

   localparam int N_ROWS      = 5;
   localparam int SEEK_MARGIN = 1100;

   // Stimulus table. A seek target of -1 means no seek; chips are the first ten in octal.
   string       row_name    [N_ROWS] = '{"prn1_start", "prn2_doppler", "prn3_seek",
                                          "prn4_wrap", "prn19_clear"};
   int          row_prn     [N_ROWS] = '{1, 2, 3, 4, 19};
   int          row_doppler [N_ROWS] = '{0, 1500, -900, 3000, -2500};
   int          row_nsamp   [N_ROWS] = '{64, 200, 120, 120, 160};
   int          row_seek    [N_ROWS] = '{-1, -1, 700, 1020, -1};
   logic [9:0]  row_chips   [N_ROWS] = '{10'o1440, 10'o1620, 10'o1710, 10'o1744, 10'o1633};

   // Standard G2 delay in chips for PRN 1 to 32.
   int g2_delay [32] = '{5, 6, 7, 8, 17, 18, 139, 140, 141, 251, 252, 254, 255, 256, 257,
                         258, 469, 470, 471, 472, 473, 474, 509, 512, 513, 514, 515, 516,
                         859, 860, 861, 862};
   int cos_tab [8] = '{2, 1, 0, -1, -2, -1, 0, 1};
   int sin_tab [8] = '{0, 1, 2, 1, 0, -1, -2, -1};

   logic clk, rst_i, sample_valid_i, seek_en_i, acc_clear_i;
   sample_t     sample_i;
   doppler_t    doppler_i;
   prn_t        prn_i;
   chip_shift_t seek_target_i, code_shift_o;
   logic        seeking_o, acc_update_o, chip_o;
   accum_t      acc_i_o, acc_q_o;

   // Reference model state.
   logic           g1_seq [`CODE_LENGTH];
   logic           g2_seq [`CODE_LENGTH];
   int             m_pos, m_target, exp_idx, n_strobe, n_update;
   logic           m_seek, exp_chip;
   code_phase_t    m_code_acc;
   carrier_phase_t m_carrier;
   accum_t         m_sum_i, m_sum_q;
   logic [2:0]     vhist;
   int             ti_hist [2];
   int             tq_hist [2];
   logic [9:0]     first_chips;
   logic [31:0]    lfsr_state = 32'he6dc;
   int             errors, fail_tests;
   string          cur_name = "reset";

   subchannel dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("mismatch %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
      errors++;
   endtask

   task automatic report_error(input string msg);
      $display("error in %s: %s", cur_name, msg);
      errors++;
   endtask

   // Fibonacci LFSR with taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic sample_t next_sample();
      sample_t s;
      s = '0;
      for (int i = 0; i < `SAMPLE_WIDTH; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         s = {s[`SAMPLE_WIDTH-2:0], lfsr_state[0]};
      end
      return s;
   endfunction

   // One full period of the G1 and G2 outputs from the all-ones state.
   task automatic build_code_tables();
      logic [10:1] g1;
      logic [10:1] g2;
      g1 = '1;
      g2 = '1;
      for (int i = 0; i < `CODE_LENGTH; i++) begin
         g1_seq[i] = g1[10];
         g2_seq[i] = g2[10];
         g1 = {g1[9:1], g1[3] ^ g1[10]};
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   endtask

   // Gold chip as G1 XOR the delayed G2 sequence.
   function automatic logic gold_chip(input int prn, input int pos);
      int d;
      d = g2_delay[(prn == 0) ? 31 : prn - 1];
      return g1_seq[pos] ^ g2_seq[(pos + `CODE_LENGTH - d) % `CODE_LENGTH];
   endfunction

   always @(posedge clk) begin
      logic                     step;
      logic [`CODE_ACC_WIDTH:0] code_sum;
      int                       idx;
      if (rst_i) begin
         m_pos = 0;
         m_seek = 1'b0;
         m_code_acc = '0;
         m_carrier = '0;
         m_sum_i = '0;
         m_sum_q = '0;
         vhist = '0;
         n_strobe = 0;
         n_update = 0;
      end else begin
         // Outputs here were set on the previous edge.
         assert (acc_update_o == vhist[2])
            else report_mismatch("acc_update_o", int'(vhist[2]), int'(acc_update_o));
         assert (acc_i_o == m_sum_i) else report_mismatch("acc_i_o", m_sum_i, acc_i_o);
         assert (acc_q_o == m_sum_q) else report_mismatch("acc_q_o", m_sum_q, acc_q_o);
         assert (int'(code_shift_o) == m_pos)
            else report_mismatch("code_shift_o", m_pos, int'(code_shift_o));
         assert (seeking_o == m_seek)
            else report_mismatch("seeking_o", int'(m_seek), int'(seeking_o));
         if (vhist[0]) begin
            assert (chip_o == exp_chip) else report_mismatch("chip_o", exp_chip, chip_o);
            if (exp_idx < 40 && exp_idx % 4 == 0) begin
               first_chips[9 - exp_idx / 4] = chip_o;
            end
         end
         if (acc_update_o) begin
            n_update++;
         end
         // A clear keeps only the product that meets it.
         if (acc_clear_i) begin
            m_sum_i = vhist[1] ? accum_t'(ti_hist[1]) : '0;
            m_sum_q = vhist[1] ? accum_t'(tq_hist[1]) : '0;
         end else if (vhist[1]) begin
            m_sum_i = m_sum_i + accum_t'(ti_hist[1]);
            m_sum_q = m_sum_q + accum_t'(tq_hist[1]);
         end
         code_sum = {1'b0, m_code_acc} + {1'b0, `CODE_INC};
         step = (sample_valid_i && code_sum[`CODE_ACC_WIDTH]) ||
                (m_seek && !sample_valid_i && m_pos != m_target);
         vhist = {vhist[1:0], sample_valid_i};
         ti_hist[1] = ti_hist[0];
         tq_hist[1] = tq_hist[0];
         if (sample_valid_i) begin
            exp_chip = gold_chip(int'(prn_i), m_pos);
            exp_idx = n_strobe;
            n_strobe++;
            idx = int'(m_carrier[`CARRIER_ACC_WIDTH-1 -: `LUT_INDEX_WIDTH]);
            ti_hist[0] = int'(sample_i) * cos_tab[idx] * (exp_chip ? -1 : 1);
            tq_hist[0] = int'(sample_i) * sin_tab[idx] * (exp_chip ? -1 : 1);
            m_carrier = m_carrier + `F_IF_INC +
               {{(`CARRIER_ACC_WIDTH-`DOPPLER_WIDTH){doppler_i[`DOPPLER_WIDTH-1]}}, doppler_i};
            m_code_acc = code_sum[`CODE_ACC_WIDTH-1:0];
         end
         if (seek_en_i) begin
            m_seek = 1'b1;
            m_target = int'(seek_target_i);
         end else if (m_seek && m_pos == m_target && !step) begin
            m_seek = 1'b0;
         end
         if (step) begin
            m_pos = (m_pos == `CODE_LENGTH - 1) ? 0 : m_pos + 1;
         end
      end
   end

   task automatic do_seek(input int target);
      int guard;
      @(posedge clk);
      sample_valid_i <= 1'b0;
      acc_clear_i    <= 1'b0;
      seek_en_i      <= 1'b1;
      seek_target_i  <= chip_shift_t'(target);
      @(posedge clk);
      seek_en_i <= 1'b0;
      @(negedge clk);
      assert (seeking_o) else report_error("seeking_o did not rise after the request");
      guard = 0;
      while (seeking_o && guard < SEEK_MARGIN) begin
         @(negedge clk);
         guard++;
      end
      assert (!seeking_o) else report_error("seek did not finish in time");
      assert (int'(code_shift_o) == target)
         else report_mismatch("seek end position", target, int'(code_shift_o));
   endtask

   task automatic run_row(input int r);
      int errs_before;
      int driven;
      int guard;
      errs_before = errors;
      driven = 0;
      cur_name = row_name[r];
      @(posedge clk);
      prn_i     <= prn_t'(row_prn[r]);
      doppler_i <= doppler_t'(row_doppler[r]);
      rst_i     <= 1'b1;
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      assert (!acc_update_o && !seeking_o && acc_i_o == '0 && acc_q_o == '0)
         else report_error("outputs not cleared by reset");
      for (int k = 0; k < row_nsamp[r]; k++) begin
         if (k == 40 && row_seek[r] >= 0) begin
            do_seek(row_seek[r]);
         end
         // An idle cycle every eighth sample.
         if (k % 8 == 7) begin
            @(posedge clk);
            sample_valid_i <= 1'b0;
            acc_clear_i    <= 1'b0;
         end
         @(posedge clk);
         sample_valid_i <= 1'b1;
         sample_i       <= next_sample();
         acc_clear_i    <= (k == row_nsamp[r] / 2);
         driven++;
      end
      @(posedge clk);
      sample_valid_i <= 1'b0;
      acc_clear_i    <= 1'b0;
      guard = 0;
      while (n_update != driven && guard < 10) begin
         @(negedge clk);
         guard++;
      end
      assert (n_update == driven) else report_mismatch("update count", driven, n_update);
      assert (first_chips == row_chips[r])
         else report_mismatch("first ten chips", int'(row_chips[r]), int'(first_chips));
      // Clear with no product pending.
      @(posedge clk);
      acc_clear_i <= 1'b1;
      @(posedge clk);
      acc_clear_i <= 1'b0;
      @(negedge clk);
      assert (acc_i_o == '0 && acc_q_o == '0) else report_error("sums not zero after clear");
      if (errors != errs_before) begin
         fail_tests++;
      end
      $display("%s: %s, %0d errors", cur_name, (errors == errs_before) ? "ok" : "bad",
               errors - errs_before);
   endtask

   initial begin
      int limit;
      limit = 0;
      for (int r = 0; r < N_ROWS; r++) begin
         limit += row_nsamp[r] * 4 + SEEK_MARGIN;
      end
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not complete", limit);
      $display("Test failed");
      $finish;
   end

   initial begin
      build_code_tables();
      rst_i          = 1'b1;
      sample_valid_i = 1'b0;
      sample_i       = '0;
      doppler_i      = '0;
      prn_i          = prn_t'(1);
      seek_en_i      = 1'b0;
      seek_target_i  = '0;
      acc_clear_i    = 1'b0;
      errors         = 0;
      fail_tests     = 0;
      repeat (2) @(posedge clk);
      rst_i <= 1'b0;
      for (int r = 0; r < N_ROWS; r++) begin
         run_row(r);
      end
      $display("%0d tests run, %0d failed, %0d errors", N_ROWS, fail_tests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
